// File: Makefile
VERILATOR ?= verilator
TOP       ?= trace_port_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run and check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
  output logic clk_i,
  output logic reset_i
);

  initial begin
    clk_i   = 1'b0;
    reset_i = 1'b1;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
  end

  // 4 ns period
  always #2 clk_i = ~clk_i;

endmodule

`default_nettype wire

// File: bench/trace_monitor.sv
// uart byte monitor
`timescale 1ns/1ns
`default_nettype none

module trace_monitor (
  input logic        clk_i,
  input logic        reset_i,
  input logic        tx,
  input logic [31:0] csr_rdata
);
  import trace_pkg::*;

  logic [7:0] exp_q [$];
  logic [7:0] rx_byte;
  logic [7:0] exp_byte;
  logic       stop_bit;
  string      test_name = "none";
  int         errors = 0;

  task automatic push_expected(input logic [7:0] b);
    exp_q.push_back(b);
  endtask

  // old CSR value on the write cycle
  task automatic check_rdata(input logic [31:0] exp);
    if (csr_rdata !== exp) begin
      $display("** Error test %s: expected 0x%08h, actual 0x%08h",
               test_name, exp, csr_rdata);
      errors++;
    end
  endtask

  task automatic check_idle();
    if (tx !== 1'b1) begin
      $display("tx is not idle high in test %s", test_name);
      errors++;
    end
  endtask

  always begin
    @(posedge clk_i);
    if (!reset_i && tx === 1'b0) begin
      // move to the middle of the start bit
      repeat (baud_div / 2) @(posedge clk_i);
      for (int i = 0; i < 8; i++) begin
        repeat (baud_div) @(posedge clk_i);
        rx_byte[i] = tx;
      end
      repeat (baud_div) @(posedge clk_i);
      stop_bit = tx;
      if (stop_bit !== 1'b1) begin
        $display("framing error in test %s: stop bit is not high", test_name);
        errors++;
      end
      if (exp_q.size() == 0) begin
        $display("unexpected byte 0x%02h on tx in test %s", rx_byte, test_name);
        errors++;
      end else begin
        exp_byte = exp_q.pop_front();
        if (rx_byte !== exp_byte) begin
          $display("** Error test %s: expected 0x%02h, actual 0x%02h",
                   test_name, exp_byte, rx_byte);
          errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/trace_patterns.txt
# t name | l level | c op operand old_value | e expected_byte | x random_count | d drain
# op 1 write 2 set 3 clear 4 write_imm 5 set_imm 6 clear_imm, all values hex
t plain
c 1 41 0 c 1 42 41 c 1 43 42
e 41 e 42 e 43
d
t zeros
c 1 0 43 c 1 55 0 c 1 0 55
e 04 e 55 e fe
d
t nested
l 1
c 1 11 0 c 1 0 11 c 1 22 0
l 3
c 1 0 22
e 11 e 02 e 22 e fe e 00 e ff
d
t csr_ops
c 1 3c 0 c 2 41 3c c 3 0c 7d
c 4 1f 71 c 6 0f 1f c 5 03 10
e 3c e 7d e 71 e 1f e 10 e 13
d
t burst
x 14
d

// File: bench/trace_port_checker.sv
// trace port assertions
`timescale 1ns/1ns
`default_nettype none

module trace_port_checker (
  input logic clk_i,
  input logic reset_i,
  input logic tx,
  input logic next,
  input logic have_next,
  input logic queue_nonempty,
  input logic tx_idle
);

  tx_high_in_reset: assert property (@(posedge clk_i) reset_i |=> tx)
    else $error("tx low during reset");

  // a pull needs a byte between the pointers
  next_needs_data: assert property (@(posedge clk_i) disable iff (reset_i)
    next |-> queue_nonempty)
    else $error("next while the queue is empty");

  idle_line_high: assert property (@(posedge clk_i) disable iff (reset_i)
    (tx_idle && !have_next) |-> tx)
    else $error("tx low while idle");

endmodule

bind trace_port trace_port_checker trace_port_checker_inst (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .tx             (tx),
  .next           (next),
  .have_next      (have_next),
  .queue_nonempty (byte_queue_inst.in_ptr != byte_queue_inst.out_ptr),
  .tx_idle        (uart_tx_inst.state == 2'd0)
);

`default_nettype wire

// File: bench/trace_port_tb.sv
// trace port testbench
`timescale 1ns/1ns
`default_nettype none

module trace_port_tb;
  import trace_pkg::*;

  logic        clk_i;
  logic        reset_i;
  csr_req_t    csr_req;
  prio_t       level;
  logic [31:0] csr_rdata;
  logic        tx;
  int          fd;
  int          code;
  int          tests;
  int          fails;
  int          start_err;
  logic        timed_out;
  logic [31:0] rng;
  string       name;

  clock_gen clock_gen_inst (.clk_i(clk_i), .reset_i(reset_i));

  trace_port trace_port_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .csr_req   (csr_req),
    .level     (level),
    .csr_rdata (csr_rdata),
    .tx        (tx)
  );

  trace_monitor mon (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .tx        (tx),
    .csr_rdata (csr_rdata)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic drive_write(input logic [31:0] op, input logic [31:0] arg);
    @(negedge clk_i);
    csr_req.enable = 1'b1;
    csr_req.addr   = trace_csr_addr;
    csr_req.op     = csr_op_t'(op[2:0]);
    // immediate ops must ignore rs1_data
    csr_req.rs1_data = (op >= 4) ? 32'hffff_ffff : arg;
    csr_req.zimm     = (op >= 4) ? arg[4:0] : 5'd0;
  endtask

  task automatic release_req();
    @(negedge clk_i);
    csr_req = '0;
  endtask

  task automatic wait_drain();
    int cnt;
    int limit;
    cnt   = 0;
    limit = mon.exp_q.size() * baud_div * 12 + 64;
    while (mon.exp_q.size() > 0 && cnt < limit) begin
      @(posedge clk_i);
      cnt++;
    end
    tests++;
    if (mon.exp_q.size() > 0) begin
      $display("timeout in test %s: tx bytes still missing", name);
      fails++;
      timed_out = 1'b1;
    end else begin
      $display("test %s: %0d errors", name, fails + mon.errors - start_err);
    end
  endtask

  task automatic run_patterns();
    string       tok;
    string       rest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [7:0]  r;
    while (!timed_out && $fscanf(fd, " %s", tok) == 1) begin
      case (tok)
        "#": code = $fgets(rest, fd);
        "t": begin
          code      = $fscanf(fd, " %s", name);
          mon.test_name = name;
          start_err = fails + mon.errors;
        end
        "l": begin
          code = $fscanf(fd, " %h", a);
          @(negedge clk_i);
          level = prio_t'(a[1:0]);
        end
        "c": begin
          code = $fscanf(fd, " %h %h %h", a, b, c);
          drive_write(a, b);
          mon.check_rdata(c);
          release_req();
        end
        "e": begin
          code = $fscanf(fd, " %h", a);
          mon.push_expected(a[7:0]);
        end
        "x": begin
          code = $fscanf(fd, " %h", a);
          for (int i = 0; i < a; i++) begin
            rng = xorshift(rng);
            r   = (rng[7:0] == 8'd0) ? 8'h5a : rng[7:0];
            mon.push_expected(r);
            drive_write(32'd1, {24'd0, r});
          end
          release_req();
        end
        "d": wait_drain();
        default: begin
          $display("unknown pattern command %s", tok);
          fails++;
        end
      endcase
    end
  endtask

  initial begin
    int cnt;
    csr_req   = '0;
    level     = prio_t'(prio_num - 1);
    tests     = 0;
    fails     = 0;
    timed_out = 1'b0;
    rng       = 32'd79756;
    name      = "reset";
    mon.test_name = name;
    cnt       = 0;
    while (reset_i !== 1'b0 && cnt < 100) begin
      @(negedge clk_i);
      cnt++;
    end
    // line stays idle until the first write
    for (int i = 0; i < 20; i++) begin
      @(negedge clk_i);
      mon.check_idle();
    end
    fd = $fopen("bench/trace_patterns.txt", "r");
    if (cnt >= 100 || fd == 0) begin
      $display("reset did not finish or pattern file could not be opened");
      $display("test failed");
      $finish;
    end else begin
      run_patterns();
      $fclose(fd);
      $display("%0d tests run, %0d errors", tests, fails + mon.errors);
      if (fails + mon.errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: common/trace_pkg.sv
// trace port shared definitions
`default_nettype none

package trace_pkg;

  // csr addressing
  typedef logic [11:0] csr_addr_t;

  // user read/write CSR space
  localparam csr_addr_t trace_csr_addr = 12'h8c0;

  typedef enum logic [2:0] {
    op_none      = 3'd0,
    op_write     = 3'd1,
    op_set       = 3'd2,
    op_clear     = 3'd3,
    op_write_imm = 3'd4,
    op_set_imm   = 3'd5,
    op_clear_imm = 3'd6
  } csr_op_t;

  typedef struct packed {
    logic        enable;
    csr_addr_t   addr;
    csr_op_t     op;
    logic [31:0] rs1_data;
    logic [4:0]  zimm;
  } csr_req_t;

  // interrupt priority, lower is more urgent
  typedef logic [1:0] prio_t;

  localparam int prio_num = 4;

  // circular byte queue
  localparam int queue_depth = 64;

  typedef logic [5:0] queue_ptr_t;

  // up to three bytes per cycle, entry0 lands first
  typedef struct packed {
    logic [1:0] count;
    logic [7:0] entry0;
    logic [7:0] entry1;
    logic [7:0] entry2;
  } queue_wr_t;

  // clocks per uart bit
  localparam int baud_div = 8;

endpackage

`default_nettype wire

// File: flist.f
common/trace_pkg.sv
logic/csr_reg.sv
trace_fifo/frame_ctrl.sv
trace_fifo/byte_queue.sv
logic/uart_tx.sv
logic/trace_port.sv
bench/trace_port_checker.sv
bench/clock_gen.sv
bench/trace_monitor.sv
bench/trace_port_tb.sv

// File: logic/csr_reg.sv
// trace byte CSR
`timescale 1ns/1ns
`default_nettype none

module csr_reg (
  input  logic                clk_i,
  input  logic                reset_i,
  input  trace_pkg::csr_req_t csr_req,
  output logic                wr_strobe,
  output logic [7:0]          new_byte,
  output logic [31:0]         rdata
);
  import trace_pkg::*;

  logic [7:0]  byte_q;
  logic [31:0] operand;
  logic        is_imm;

  assign wr_strobe = csr_req.enable && (csr_req.addr == trace_csr_addr) &&
                     (csr_req.op != op_none);

  assign is_imm = (csr_req.op == op_write_imm) || (csr_req.op == op_set_imm) ||
                  (csr_req.op == op_clear_imm);

  // zimm is zero-extended
  assign operand = is_imm ? {27'd0, csr_req.zimm} : csr_req.rs1_data;

  always_comb begin
    case (csr_req.op)
      op_write, op_write_imm: new_byte = operand[7:0];
      op_set, op_set_imm:     new_byte = byte_q | operand[7:0];
      op_clear, op_clear_imm: new_byte = byte_q & ~operand[7:0];
      default:                new_byte = byte_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      byte_q <= 8'd0;
    end else if (wr_strobe) begin
      byte_q <= new_byte;
    end
  end

  // old value for the read side
  assign rdata = {24'd0, byte_q};

endmodule

`default_nettype wire

// File: logic/trace_port.sv
// trace port top
`timescale 1ns/1ns
`default_nettype none

module trace_port (
  input  logic                clk_i,
  input  logic                reset_i,
  input  trace_pkg::csr_req_t csr_req,
  input  trace_pkg::prio_t    level,
  output logic [31:0]         csr_rdata,
  output logic                tx
);
  import trace_pkg::*;

  logic      wr_strobe;
  logic [7:0] new_byte;
  queue_wr_t wr_req;
  logic [7:0] rd_byte;
  logic      have_next;
  logic      next;

  csr_reg csr_reg_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .csr_req   (csr_req),
    .wr_strobe (wr_strobe),
    .new_byte  (new_byte),
    .rdata     (csr_rdata)
  );

  frame_ctrl frame_ctrl_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_strobe (wr_strobe),
    .new_byte  (new_byte),
    .level     (level),
    .wr_req    (wr_req)
  );

  byte_queue byte_queue_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_req    (wr_req),
    .next      (next),
    .rd_byte   (rd_byte),
    .have_next (have_next)
  );

  uart_tx uart_tx_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .rd_byte   (rd_byte),
    .have_next (have_next),
    .next      (next),
    .tx        (tx)
  );

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
// 8N1 uart transmitter
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic [7:0] rd_byte,
  input  logic       have_next,
  output logic       next,
  output logic       tx
);
  import trace_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } state_t;

  state_t                        state;
  logic [$clog2(baud_div)-1:0]   baud_cnt;
  logic [2:0]                    bit_idx;
  logic [7:0]                    shift;
  logic                          bit_end;

  assign bit_end = baud_cnt == ($clog2(baud_div))'(baud_div - 1);

  // pull one byte whenever idle
  assign next = (state == st_idle) && have_next;

  always_ff @(posedge clk_i) begin
    if (next) begin
      shift <= rd_byte;
    end else if (state == st_data && bit_end) begin
      shift <= shift >> 1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state    <= st_idle;
      baud_cnt <= '0;
      bit_idx  <= 3'd0;
      tx       <= 1'b1;
    end else begin
      baud_cnt <= (state == st_idle || bit_end) ? '0 : baud_cnt + 1'b1;
      case (state)
        st_idle: begin
          tx <= ~next;
          if (next) begin
            state <= st_start;
          end
        end
        st_start: begin
          if (bit_end) begin
            state   <= st_data;
            bit_idx <= 3'd0;
            tx      <= shift[0];
          end
        end
        st_data: begin
          if (bit_end) begin
            if (bit_idx == 3'd7) begin
              state <= st_stop;
              tx    <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              tx      <= shift[1];
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: trace_fifo/byte_queue.sv
// circular trace byte queue
`timescale 1ns/1ns
`default_nettype none

module byte_queue (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  trace_pkg::queue_wr_t wr_req,
  input  logic                 next,
  output logic [7:0]           rd_byte,
  output logic                 have_next
);
  import trace_pkg::*;

  logic [7:0] mem [queue_depth];
  queue_ptr_t in_ptr;
  queue_ptr_t out_ptr;
  queue_ptr_t in_ptr_nxt;
  queue_ptr_t out_ptr_nxt;

  assign in_ptr_nxt  = queue_ptr_t'(in_ptr + queue_ptr_t'(wr_req.count));
  assign out_ptr_nxt = queue_ptr_t'(out_ptr + queue_ptr_t'(next));

  // entries go to consecutive slots from in_ptr
  always_ff @(posedge clk_i) begin
    if (wr_req.count > 2'd0) begin
      mem[in_ptr] <= wr_req.entry0;
    end
    if (wr_req.count > 2'd1) begin
      mem[queue_ptr_t'(in_ptr + 6'd1)] <= wr_req.entry1;
    end
    if (wr_req.count > 2'd2) begin
      mem[queue_ptr_t'(in_ptr + 6'd2)] <= wr_req.entry2;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_ptr    <= '0;
      out_ptr   <= '0;
      have_next <= 1'b0;
    end else begin
      in_ptr    <= in_ptr_nxt;
      out_ptr   <= out_ptr_nxt;
      have_next <= in_ptr_nxt != out_ptr_nxt;
    end
  end

  assign rd_byte = mem[out_ptr];

endmodule

`default_nettype wire

// File: trace_fifo/frame_ctrl.sv
// trace frame control
`timescale 1ns/1ns
`default_nettype none

module frame_ctrl (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 wr_strobe,
  input  logic [7:0]           new_byte,
  input  trace_pkg::prio_t     level,
  output trace_pkg::queue_wr_t wr_req
);
  import trace_pkg::*;

  // per level frame state
  logic [prio_num-1:0]      has_zero;
  logic [prio_num-1:0][7:0] length;
  prio_t                    prev_level;

  logic       falling;
  logic       rising;
  logic       cur_hz;
  logic [7:0] cur_len;
  logic       nxt_hz;
  logic [7:0] nxt_len;
  logic       is_zero;
  logic [7:0] byte_out;
  logic [7:0] close_marker;

  // first marker counts forward, later ones point back
  function automatic logic [7:0] marker(input logic hz, input logic [7:0] len);
    return hz ? (8'd0 - len) : (len + 8'd1);
  endfunction

  assign falling = level < prev_level;
  assign rising  = level > prev_level;

  always_comb begin
    // a new nested frame starts empty
    cur_hz  = falling ? 1'b0 : has_zero[level];
    cur_len = falling ? 8'd0 : length[level];

    is_zero  = new_byte == 8'd0;
    byte_out = is_zero ? marker(cur_hz, cur_len) : new_byte;

    nxt_hz  = cur_hz;
    nxt_len = cur_len;
    if (wr_strobe) begin
      if (is_zero) begin
        nxt_hz  = 1'b1;
        // marker counts itself
        nxt_len = 8'd1;
      end else begin
        nxt_len = cur_len + 8'd1;
      end
    end

    close_marker = marker(has_zero[prev_level], length[prev_level]);
  end

  always_comb begin
    wr_req = '0;
    if (rising) begin
      // close old frame, then the delimiter, then any new byte
      wr_req.entry0 = close_marker;
      wr_req.entry1 = 8'd0;
      wr_req.entry2 = byte_out;
      wr_req.count  = wr_strobe ? 2'd3 : 2'd2;
    end else begin
      wr_req.entry0 = byte_out;
      wr_req.count  = {1'b0, wr_strobe};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      has_zero   <= '0;
      length     <= '0;
      prev_level <= prio_t'(prio_num - 1);
    end else begin
      has_zero[level] <= nxt_hz;
      length[level]   <= nxt_len;
      prev_level      <= level;
    end
  end

endmodule

`default_nettype wire
